/* rtl/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data and address width
`define LSU_XLEN 32

// axi id width
`define LSU_ID_W 4

`define LSU_RD_W 5 // register tag

`endif

/* rtl/lsu_pkg.sv */
package lsu_pkg;

    // funct3 codes of loads and stores
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'd0,
        MEM_HALF   = 3'd1,
        MEM_WORD   = 3'd2,
        MEM_BYTE_U = 3'd4,
        MEM_HALF_U = 3'd5
    } mem_width_e;

    typedef enum logic [1:0] {
        AXI_OKAY   = 2'd0,
        AXI_EXOKAY = 2'd1,
        AXI_SLVERR = 2'd2,
        AXI_DECERR = 2'd3
    } axi_resp_e;

endpackage

/* rtl/lsu_access_if.sv */
`include "lsu_defs.svh"

interface lsu_access_if
    import lsu_pkg::*;
();

    logic [`LSU_XLEN-1:0]   word_addr;  // low two bits zero
    logic [1:0]             byte_off;
    mem_width_e             width;
    logic                   is_store;
    logic                   misaligned;
    logic [`LSU_XLEN-1:0]   wdata;      // shifted into its lane
    logic [`LSU_XLEN/8-1:0] wstrb;
    logic [`LSU_RD_W-1:0]   rd;

    modport req (
        output word_addr, byte_off, width, is_store, misaligned, wdata, wstrb, rd
    );

    modport ctrl (input is_store, misaligned);

    modport load (input byte_off, width);

endinterface

/* rtl/lsu_req_stage.sv */
`include "lsu_defs.svh"

module lsu_req_stage
    import lsu_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 capture_en,
    input  logic [`LSU_XLEN-1:0] addr,
    input  logic [`LSU_XLEN-1:0] store_data,
    input  mem_width_e           width,
    input  logic                 is_store,
    input  logic [`LSU_RD_W-1:0] rd,
    lsu_access_if.req            acc
);

    logic [`LSU_XLEN-1:0] addr_q;
    logic [`LSU_XLEN-1:0] data_q;
    mem_width_e           width_q;
    logic                 is_store_q;
    logic [`LSU_RD_W-1:0] rd_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            width_q    <= MEM_WORD;
            is_store_q <= 1'b0;
        end else if (capture_en) begin
            width_q    <= width;
            is_store_q <= is_store;
        end
    end

    always_ff @(posedge clock) begin
        if (capture_en) begin
            addr_q <= addr;
            data_q <= store_data;
            rd_q   <= rd;
        end
    end

    assign acc.word_addr = {addr_q[`LSU_XLEN-1:2], 2'b00};
    assign acc.byte_off  = addr_q[1:0];
    assign acc.width     = width_q;
    assign acc.is_store  = is_store_q;
    assign acc.rd        = rd_q;
    assign acc.wdata     = data_q << {addr_q[1:0], 3'b000}; // byte lane = offset * 8

    always_comb begin
        case (width_q)
            MEM_BYTE, MEM_BYTE_U: acc.wstrb = 4'b0001 << addr_q[1:0];
            MEM_HALF, MEM_HALF_U: acc.wstrb = 4'b0011 << addr_q[1:0];
            default:              acc.wstrb = 4'b1111;
        endcase
    end

    always_comb begin
        case (width_q)
            MEM_HALF, MEM_HALF_U: acc.misaligned = addr_q[0];
            MEM_WORD:             acc.misaligned = |addr_q[1:0];
            default:              acc.misaligned = 1'b0; // bytes never misalign
        endcase
    end

endmodule

/* rtl/lsu_load_extract.sv */
`include "lsu_defs.svh"

module lsu_load_extract
    import lsu_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load_en,
    input  logic                 clear,
    input  logic [`LSU_XLEN-1:0] rdata,
    lsu_access_if.load           acc,
    output logic [`LSU_XLEN-1:0] result
);

    logic [`LSU_XLEN-1:0] lane;
    logic [`LSU_XLEN-1:0] ext;

    // addressed byte or half moved down to bit 0
    assign lane = rdata >> {acc.byte_off, 3'b000};

    always_comb begin
        case (acc.width)
            MEM_BYTE: begin
                ext = {{(`LSU_XLEN-8){lane[7]}}, lane[7:0]};
            end
            MEM_HALF: begin
                ext = {{(`LSU_XLEN-16){lane[15]}}, lane[15:0]};
            end
            MEM_BYTE_U: begin
                ext = {{(`LSU_XLEN-8){1'b0}}, lane[7:0]};
            end
            MEM_HALF_U: begin
                ext = {{(`LSU_XLEN-16){1'b0}}, lane[15:0]};
            end
            default: begin
                ext = rdata; // lw
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            result <= '0; // stores and errors return zero
        end else if (load_en) begin
            result <= ext;
        end
    end

endmodule

/* rtl/lsu_ctrl.sv */
module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    output logic       capture_en,
    lsu_access_if.ctrl acc,
    output logic       awvalid,
    input  logic       awready,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    output logic       bready,
    input  logic [1:0] bresp,
    output logic       arvalid,
    input  logic       arready,
    input  logic       rvalid,
    output logic       rready,
    input  logic [1:0] rresp,
    output logic       load_en,
    output logic       clear,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       out_err
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DECODE,
        S_BUS,
        S_DONE
    } state_e;

    state_e state;
    logic   aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic   aw_done, w_done, b_done, r_done;
    logic   bus_done;
    logic   err_q;

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign b_hs  = bvalid & bready;
    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;

    assign in_ready   = (state == S_IDLE);
    assign capture_en = in_valid & in_ready;
    assign out_valid  = (state == S_DONE);
    assign out_err    = err_q;
    assign load_en    = r_hs && (rresp == AXI_OKAY);
    assign clear      = ((state == S_DECODE) && (acc.is_store || acc.misaligned))
                      || (r_hs && (rresp != AXI_OKAY));
    // b cannot precede aw, so a store ends on the later of w and b
    assign bus_done   = acc.is_store ? (aw_done & w_done & b_done) : r_done;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:   if (capture_en) state <= S_DECODE;
                S_DECODE: state <= acc.misaligned ? S_DONE : S_BUS;
                S_BUS:    if (bus_done) state <= S_DONE;
                S_DONE:   if (out_ready) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else if ((state == S_DECODE) && !acc.misaligned) begin
            awvalid <= acc.is_store;
            wvalid  <= acc.is_store;
            bready  <= acc.is_store;
            arvalid <= !acc.is_store;
            rready  <= !acc.is_store;
        end else begin
            if (aw_hs) awvalid <= 1'b0;
            if (w_hs)  wvalid  <= 1'b0;
            if (b_hs)  bready  <= 1'b0;
            if (ar_hs) arvalid <= 1'b0;
            if (r_hs)  rready  <= 1'b0;
        end
    end

    // per-channel completion, any order
    always_ff @(posedge clock) begin
        if (reset || (state == S_DECODE)) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            b_done  <= 1'b0;
            r_done  <= 1'b0;
        end else begin
            if (aw_hs) aw_done <= 1'b1;
            if (w_hs)  w_done  <= 1'b1;
            if (b_hs)  b_done  <= 1'b1;
            if (r_hs)  r_done  <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || capture_en) begin
            err_q <= 1'b0;
        end else if ((state == S_DECODE) && acc.misaligned) begin
            err_q <= 1'b1;
        end else if ((b_hs && (bresp != AXI_OKAY)) || (r_hs && (rresp != AXI_OKAY))) begin
            err_q <= 1'b1; // slverr or decerr
        end
    end

endmodule

/* rtl/lsu_top.sv */
`include "lsu_defs.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`LSU_XLEN-1:0]   in_addr,
    input  logic [`LSU_XLEN-1:0]   in_wdata,
    input  mem_width_e             in_width,
    input  logic                   in_is_store,
    input  logic [`LSU_RD_W-1:0]   in_rd,

    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`LSU_XLEN-1:0]   out_data,
    output logic [`LSU_RD_W-1:0]   out_rd,
    output logic                   out_err,

    output logic                   awvalid,
    input  logic                   awready,
    output logic [`LSU_XLEN-1:0]   awaddr,
    output logic [`LSU_ID_W-1:0]   awid,
    output logic [7:0]             awlen,
    output logic [2:0]             awsize,
    output logic [1:0]             awburst,

    output logic                   wvalid,
    input  logic                   wready,
    output logic [`LSU_XLEN-1:0]   wdata,
    output logic [`LSU_XLEN/8-1:0] wstrb,
    output logic                   wlast,

    input  logic                   bvalid,
    output logic                   bready,
    input  logic [1:0]             bresp,
    input  logic [`LSU_ID_W-1:0]   bid,

    output logic                   arvalid,
    input  logic                   arready,
    output logic [`LSU_XLEN-1:0]   araddr,
    output logic [`LSU_ID_W-1:0]   arid,
    output logic [7:0]             arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,

    input  logic                   rvalid,
    output logic                   rready,
    input  logic [`LSU_XLEN-1:0]   rdata,
    input  logic [1:0]             rresp,
    input  logic                   rlast,
    input  logic [`LSU_ID_W-1:0]   rid
);

    logic capture_en;
    logic load_en;
    logic clear;

    lsu_access_if acc ();

    lsu_req_stage i_req_stage (
        .clock      (clock),
        .reset      (reset),
        .capture_en (capture_en),
        .addr       (in_addr),
        .store_data (in_wdata),
        .width      (in_width),
        .is_store   (in_is_store),
        .rd         (in_rd),
        .acc        (acc.req)
    );

    lsu_ctrl i_ctrl (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .capture_en (capture_en),
        .acc        (acc.ctrl),
        .awvalid    (awvalid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rresp      (rresp),
        .load_en    (load_en),
        .clear      (clear),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_err    (out_err)
    );

    lsu_load_extract i_load_extract (
        .clock   (clock),
        .reset   (reset),
        .load_en (load_en),
        .clear   (clear),
        .rdata   (rdata),
        .acc     (acc.load),
        .result  (out_data)
    );

    assign out_rd  = acc.rd;

    assign awaddr  = acc.word_addr;
    assign awid    = `LSU_ID_W'(1);
    assign awlen   = 8'd0;          // single beat
    assign awsize  = 3'd2;          // always a full word
    assign awburst = 2'd0;

    assign wdata   = acc.wdata;
    assign wstrb   = acc.wstrb;
    assign wlast   = wvalid;

    assign araddr  = acc.word_addr;
    assign arid    = `LSU_ID_W'(0);
    assign arlen   = 8'd0;
    assign arsize  = 3'd2;
    assign arburst = 2'd0;

endmodule

/* verif/lsu_props.sv */
module lsu_props (
    input logic clock,
    input logic reset,
    input logic in_ready,
    input logic capture_en,
    input logic awvalid, awready, wvalid, wready, bready,
    input logic arvalid, arready, rready,
    input logic load_en,
    input logic clear,
    input logic out_valid,
    input logic out_ready,
    input logic out_err
);
    timeunit 1ns;
    timeprecision 100ps;

    a_busy_after_accept: assert property (@(posedge clock) disable iff (reset)
        capture_en |=> !in_ready)
        else $error("in_ready high in the cycle after an accept");

    a_busy_in_flight: assert property (@(posedge clock) disable iff (reset)
        (out_valid || awvalid || wvalid || arvalid || bready || rready) |-> !in_ready)
        else $error("in_ready high while an access is in flight");

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    a_w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // result register must not move while held
    a_out_hold: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |-> !load_en && !clear)
        else $error("result register written while out_valid waits");

    a_out_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_err))
        else $error("out_valid or out_err changed while out_ready low");

    // only a misaligned access finishes two cycles after accept
    a_misaligned_quiet: assert property (@(posedge clock) disable iff (reset)
        out_valid && $past(capture_en, 2) |-> out_err && !(awvalid || wvalid || arvalid))
        else $error("misaligned access raised a channel valid or no error");

endmodule

/* verif/lsu_tb.sv */
`include "lsu_defs.svh"

module lsu_tb
    import lsu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200; // cycles per wait

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   in_valid, in_ready, in_is_store;
    logic [`LSU_XLEN-1:0]   in_addr, in_wdata;
    mem_width_e             in_width;
    logic [`LSU_RD_W-1:0]   in_rd;
    logic                   out_valid, out_ready, out_err;
    logic [`LSU_XLEN-1:0]   out_data;
    logic [`LSU_RD_W-1:0]   out_rd;
    logic                   awvalid, wvalid, wlast, arvalid, bready, rready;
    logic [`LSU_XLEN-1:0]   awaddr, wdata, araddr;
    logic [`LSU_ID_W-1:0]   awid, arid;
    logic [7:0]             awlen, arlen;
    logic [2:0]             awsize, arsize;
    logic [1:0]             awburst, arburst;
    logic [`LSU_XLEN/8-1:0] wstrb;
    logic                   awready = 1'b0;
    logic                   wready = 1'b0;
    logic                   arready = 1'b0;
    logic                   bvalid = 1'b0;
    logic                   rvalid = 1'b0;
    logic [1:0]             bresp = 2'd0;
    logic [1:0]             rresp = 2'd0;
    logic [`LSU_XLEN-1:0]   rdata = '0;
    logic                   rlast = 1'b1;
    logic [`LSU_ID_W-1:0]   bid = `LSU_ID_W'(1);
    logic [`LSU_ID_W-1:0]   rid = '0;

    logic [`LSU_XLEN-1:0]   mem [0:255];
    logic [`LSU_XLEN-1:0]   aw_addr_q, w_data_q;
    logic [3:0]             w_strb_q;
    logic [1:0]             b_resp_q;
    logic                   aw_got, w_got, b_pend, b_fire, r_pend, r_fire;
    int                     out_count = 0;
    logic                   out_prev = 1'b0;

    lsu_top i_lsu_top (.*);

    bind lsu_ctrl lsu_props i_props (
        .clock(clock), .reset(reset), .in_ready(in_ready),
        .capture_en(capture_en), .awvalid(awvalid), .awready(awready), .wvalid(wvalid),
        .wready(wready), .bready(bready), .arvalid(arvalid), .arready(arready),
        .rready(rready), .load_en(load_en), .clear(clear),
        .out_valid(out_valid), .out_ready(out_ready), .out_err(out_err)
    );

    always #4 clock = ~clock;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: gave up waiting for %s", what);
        $display("Test failed");
        $fatal(1, "wait timed out");
    endtask

    function automatic logic [1:0] resp_for(input logic [31:0] addr);
        return addr[31] ? AXI_SLVERR : AXI_OKAY; // upper half is unmapped
    endfunction

    // memory responder with random stalls
    always @(negedge clock) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] = '0;
            end
            aw_got = 1'b0;
            w_got = 1'b0;
            b_pend = 1'b0;
            b_fire = 1'b0;
            r_pend = 1'b0;
            r_fire = 1'b0;
        end else begin
            if (b_fire) bvalid = 1'b0;
            if (r_fire) rvalid = 1'b0;
            if (b_pend && ($urandom % 3 == 0)) begin
                bvalid = 1'b1;
                bresp  = b_resp_q;
                b_pend = 1'b0;
            end
            if (r_pend && ($urandom % 3 == 0)) begin
                rvalid = 1'b1;
                r_pend = 1'b0;
            end
            awready = awvalid && ($urandom % 3 == 0);
            if (awready) begin
                aw_addr_q = awaddr;
                aw_got = 1'b1;
            end
            wready = wvalid && ($urandom % 3 == 0);
            if (wready) begin
                w_data_q = wdata;
                w_strb_q = wstrb;
                w_got = 1'b1;
            end
            arready = arvalid && ($urandom % 3 == 0);
            if (arready) begin
                rresp  = resp_for(araddr);
                rdata  = araddr[31] ? 32'hbad0bad0 : mem[araddr[9:2]];
                r_pend = 1'b1;
            end
            if (aw_got && w_got) begin
                b_resp_q = resp_for(aw_addr_q);
                if (!aw_addr_q[31]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb_q[b]) mem[aw_addr_q[9:2]][8*b +: 8] = w_data_q[8*b +: 8];
                    end
                end
                aw_got = 1'b0;
                w_got = 1'b0;
                b_pend = 1'b1;
            end
            b_fire = bvalid && bready; // handshake on the coming edge
            r_fire = rvalid && rready;
        end
    end

    // fixed AXI fields and word addresses
    always @(negedge clock) begin
        if (!reset) begin
            compare_value("wlast", 32'(wvalid), 32'(wlast));
            if (awvalid) begin
                compare_value("awaddr", {in_addr[31:2], 2'b00}, awaddr);
                compare_value("awid", 32'd1, 32'(awid));
                compare_value("awlen", 32'd0, 32'(awlen));
                compare_value("awsize", 32'd2, 32'(awsize));
                compare_value("awburst", 32'd0, 32'(awburst));
            end
            if (arvalid) begin
                compare_value("araddr", {in_addr[31:2], 2'b00}, araddr);
                compare_value("arid", 32'd0, 32'(arid));
                compare_value("arlen", 32'd0, 32'(arlen));
                compare_value("arsize", 32'd2, 32'(arsize));
                compare_value("arburst", 32'd0, 32'(arburst));
            end
        end
    end

    // each output counted once on its rising out_valid
    always @(negedge clock) begin
        if (out_valid && !out_prev) out_count++;
        out_prev = out_valid;
    end

    task automatic run_access(input int idx, input logic is_st, input logic [2:0] width,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] exp_data, input logic exp_err);
        int    cycles;
        logic  got;
        string name;
        name = $sformatf("access %0d", idx);
        @(negedge clock);
        in_valid    = 1'b1;
        in_is_store = is_st;
        in_width    = mem_width_e'(width);
        in_addr     = addr;
        in_wdata    = data;
        in_rd       = `LSU_RD_W'(idx);
        cycles = 0;
        while (!in_ready) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT) report_timeout({name, " to be accepted"});
        end
        @(negedge clock); // taken on the edge just passed
        in_valid = 1'b0;
        cycles = 0;
        got = 1'b0;
        while (!got) begin
            out_ready = ($urandom % 3 != 0);
            if (out_valid && out_ready) begin
                compare_value({name, " data"}, exp_data, out_data);
                compare_value({name, " err"}, 32'(exp_err), 32'(out_err));
                compare_value({name, " rd"}, 32'(idx % 32), 32'(out_rd));
                got = 1'b1;
            end else begin
                @(negedge clock);
                cycles++;
                if (cycles > TIMEOUT) report_timeout({name, " result"});
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          idx;
        string       line;
        logic        v_store;
        logic [2:0]  v_width;
        logic [31:0] v_addr, v_data, v_exp;
        logic        v_err;
        void'($urandom(32'had94));
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_is_store = 1'b0;
        in_addr     = '0;
        in_wdata    = '0;
        in_width    = MEM_WORD;
        in_rd       = '0;
        out_ready   = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        compare_value("reset in_ready", 32'd1, 32'(in_ready));
        compare_value("reset valids", 32'd0,
                      32'({out_valid, awvalid, wvalid, arvalid, bready, rready}));
        fd = $fopen("verif/lsu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file verif/lsu_vectors.txt");
            $display("Test failed");
            $fatal(1, "missing vectors");
        end
        idx = 0;
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h", v_store, v_width, v_addr, v_data,
                        v_exp, v_err);
            if (n == 6) begin // comment lines do not parse
                run_access(idx, v_store, v_width, v_addr, v_data, v_exp, v_err);
                idx++;
            end
        end
        $fclose(fd);
        repeat (4) @(negedge clock);
        compare_value("output count", 32'(idx), 32'(out_count));
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* src.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_access_if.sv
rtl/lsu_req_stage.sv
rtl/lsu_load_extract.sv
rtl/lsu_ctrl.sv
rtl/lsu_top.sv
verif/lsu_props.sv
verif/lsu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
    --top-module lsu_tb -o lsu_sim && ./obj_dir/lsu_sim || exit 1

/* verif/lsu_vectors.txt */
# store width(funct3) address store_data expected_result expected_error, all hex
# stores expect result 0, errors expect result 0 and error 1
1 0 00000100 000000a1 00000000 0
1 0 00000101 123456b2 00000000 0
1 0 00000102 000000c3 00000000 0
1 0 00000103 000000d4 00000000 0
0 2 00000100 00000000 d4c3b2a1 0
1 1 00000104 ffff8765 00000000 0
1 1 00000106 0000f00d 00000000 0
0 2 00000104 00000000 f00d8765 0
1 2 00000108 80ff7f01 00000000 0
0 2 00000108 00000000 80ff7f01 0
0 0 00000100 00000000 ffffffa1 0
0 0 00000102 00000000 ffffffc3 0
0 4 00000103 00000000 000000d4 0
0 1 00000104 00000000 ffff8765 0
0 1 00000106 00000000 fffff00d 0
0 5 00000106 00000000 0000f00d 0
0 0 00000109 00000000 0000007f 0
0 1 0000010a 00000000 ffff80ff 0
1 0 0000010b 00000011 00000000 0
0 2 00000108 00000000 11ff7f01 0
0 1 00000101 00000000 00000000 1
0 2 00000102 00000000 00000000 1
1 1 00000103 0000ffff 00000000 1
1 2 00000101 0badcafe 00000000 1
0 2 00000100 00000000 d4c3b2a1 0
0 2 80000100 00000000 00000000 1
1 2 80000104 12345678 00000000 1
1 0 80000102 000000ee 00000000 1
0 2 00000104 00000000 f00d8765 0
